/* design/vi_pkg.sv */
// Core shared definitions

package vi_pkg;

	// Data path width
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0] reg_idx_t;

	// ALU operations
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_MUL
	} alu_op_t;

	// Major opcodes
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	// funct7 selectors for SUB and MUL
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	// addi x0,x0,0
	localparam word_t NOP_WORD = 32'h0000_0013;

endpackage

/* design/vi_fetch_fsm.sv */
// Wishbone instruction fetch

`timescale 1ns/100ps

module vi_fetch_fsm #(
	parameter vi_pkg::addr_t RESET_PC = '0
) (
	input  logic          clk_i,
	input  logic          arst_n_i,
	input  logic          ack_i,
	input  vi_pkg::word_t dat_i,
	input  logic          instr_ready_i,
	output logic          cyc_o,
	output logic          stb_o,
	output vi_pkg::addr_t adr_o,
	output logic          instr_valid_o,
	output vi_pkg::word_t instr_o
);

	typedef enum logic [1:0] {
		IDLE,
		BUS,
		HOLD
	} state_t;

	state_t state_q;
	state_t state_d;
	vi_pkg::addr_t pc_q;
	vi_pkg::word_t instr_q;
	logic handoff;

	assign handoff = (state_q == HOLD) && instr_ready_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: state_d = BUS;
			BUS: begin
				if (ack_i) begin
					state_d = HOLD;
				end
			end
			// Next read starts right after decode takes the word
			HOLD: begin
				if (instr_ready_i) begin
					state_d = BUS;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= IDLE;
			pc_q <= RESET_PC;
		end else begin
			state_q <= state_d;
			if (handoff) begin
				pc_q <= pc_q + 32'd4;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if ((state_q == BUS) && ack_i) begin
			instr_q <= dat_i;
		end
	end

	// Strobes stay low in HOLD, so every ack is followed by an idle cycle
	assign cyc_o = (state_q == BUS);
	assign stb_o = (state_q == BUS);
	assign adr_o = pc_q;
	assign instr_valid_o = (state_q == HOLD);
	assign instr_o = instr_q;

endmodule

/* design/vi_decoder.sv */
// Instruction decoder

`timescale 1ns/100ps

module vi_decoder (
	input  vi_pkg::word_t    instr_i,
	output vi_pkg::reg_idx_t rs1_o,
	output vi_pkg::reg_idx_t rs2_o,
	output vi_pkg::reg_idx_t rd_o,
	output vi_pkg::word_t    imm_o,
	output logic             use_imm_o,
	output vi_pkg::alu_op_t  alu_op_o,
	output logic             wr_en_o,
	output logic             is_mul_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic known;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	assign rs1_o = instr_i[19:15];
	assign rs2_o = instr_i[24:20];
	assign rd_o = instr_i[11:7];
	// I-type immediate, sign extended
	assign imm_o = {{20{instr_i[31]}}, instr_i[31:20]};

	always_comb begin
		known = 1'b0;
		use_imm_o = 1'b0;
		is_mul_o = 1'b0;
		alu_op_o = vi_pkg::ALU_ADD;
		if (opcode == vi_pkg::OPC_OP_IMM && funct3 == 3'b000) begin
			known = 1'b1;
			use_imm_o = 1'b1;
		end else if (opcode == vi_pkg::OPC_OP) begin
			if (funct7 == 7'b0000000) begin
				known = 1'b1;
				case (funct3)
					3'b000: alu_op_o = vi_pkg::ALU_ADD;
					3'b100: alu_op_o = vi_pkg::ALU_XOR;
					3'b110: alu_op_o = vi_pkg::ALU_OR;
					3'b111: alu_op_o = vi_pkg::ALU_AND;
					default: known = 1'b0;
				endcase
			end else if (funct7 == vi_pkg::FUNCT7_ALT && funct3 == 3'b000) begin
				known = 1'b1;
				alu_op_o = vi_pkg::ALU_SUB;
			end else if (funct7 == vi_pkg::FUNCT7_MULDIV && funct3 == 3'b000) begin
				known = 1'b1;
				is_mul_o = 1'b1;
				alu_op_o = vi_pkg::ALU_MUL;
			end
		end
	end

	// Unknown words and writes to x0 become bubbles
	assign wr_en_o = known && (rd_o != '0);

endmodule

/* design/vi_int_registers.sv */
// Integer register file

`timescale 1ns/100ps

module vi_int_registers (
	input  logic             clk_i,
	input  logic             arst_n_i,
	input  vi_pkg::reg_idx_t rd_addr_a_i,
	input  vi_pkg::reg_idx_t rd_addr_b_i,
	input  vi_pkg::reg_idx_t wr_addr_i,
	input  vi_pkg::word_t    wr_data_i,
	input  logic             wr_en_i,
	output vi_pkg::word_t    rd_data_a_o,
	output vi_pkg::word_t    rd_data_b_o
);

	// x0 has no storage
	vi_pkg::word_t regs_q [1:31];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_en_i && (wr_addr_i != '0)) begin
			regs_q[wr_addr_i] <= wr_data_i;
		end
	end

	assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs_q[rd_addr_a_i];
	assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs_q[rd_addr_b_i];

endmodule

/* design/vi_hazard_ctrl.sv */
// Operand forwarding and decode stall

`timescale 1ns/100ps

module vi_hazard_ctrl #(
	parameter int MUL_STAGES = 5
) (
	input  vi_pkg::reg_idx_t                  dec_rs1_i,
	input  vi_pkg::reg_idx_t                  dec_rs2_i,
	input  logic                              dec_use_imm_i,
	input  logic                              dec_is_mul_i,
	input  vi_pkg::word_t                     reg_a_i,
	input  vi_pkg::word_t                     reg_b_i,
	input  vi_pkg::reg_idx_t                  exe_rd_i,
	input  logic                              exe_wr_en_i,
	input  logic                              exe_is_mul_i,
	input  vi_pkg::word_t                     exe_data_i,
	input  vi_pkg::reg_idx_t [MUL_STAGES-1:0] mul_rd_i,
	input  logic [MUL_STAGES-1:0]             mul_valid_i,
	input  vi_pkg::reg_idx_t                  wb_rd_i,
	input  logic                              wb_wr_en_i,
	input  vi_pkg::word_t                     wb_data_i,
	output vi_pkg::word_t                     op_a_o,
	output vi_pkg::word_t                     op_b_o,
	output logic                              stall_o
);

	logic exe_hit;
	logic exe_fwd_a;
	logic exe_fwd_b;
	logic wb_fwd_a;
	logic wb_fwd_b;
	logic mul_dep;
	logic mul_ahead;

	// A MUL result is only valid once it leaves the multiply chain
	assign exe_hit = exe_wr_en_i && !exe_is_mul_i;
	assign exe_fwd_a = exe_hit && (exe_rd_i == dec_rs1_i);
	assign exe_fwd_b = exe_hit && (exe_rd_i == dec_rs2_i);
	assign wb_fwd_a = wb_wr_en_i && (wb_rd_i == dec_rs1_i);
	assign wb_fwd_b = wb_wr_en_i && (wb_rd_i == dec_rs2_i);

	// Youngest producer wins
	assign op_a_o = exe_fwd_a ? exe_data_i : (wb_fwd_a ? wb_data_i : reg_a_i);
	assign op_b_o = exe_fwd_b ? exe_data_i : (wb_fwd_b ? wb_data_i : reg_b_i);

	// Stage 0 is the MUL in execute; the value reaches writeback after the last stage
	always_comb begin
		mul_dep = 1'b0;
		for (int i = 0; i < MUL_STAGES; i++) begin
			if (mul_valid_i[i] && ((mul_rd_i[i] == dec_rs1_i) ||
					(!dec_use_imm_i && (mul_rd_i[i] == dec_rs2_i)))) begin
				mul_dep = 1'b1;
			end
		end
	end

	// ALU op waits until no older MUL is short of the last stage
	// so it neither overtakes nor meets the MUL in writeback
	assign mul_ahead = !dec_is_mul_i && (|mul_valid_i[MUL_STAGES-2:0]);

	assign stall_o = mul_dep || mul_ahead;

endmodule

/* design/vi_int_alu.sv */
// Integer ALU

`timescale 1ns/100ps

module vi_int_alu (
	input  vi_pkg::alu_op_t op_i,
	input  vi_pkg::word_t   a_i,
	input  vi_pkg::word_t   b_i,
	output vi_pkg::word_t   result_o
);

	vi_pkg::word_t product;

	// Low half only, the multiply pipe adds the latency
	assign product = a_i * b_i;

	always_comb begin
		case (op_i)
			vi_pkg::ALU_ADD: result_o = a_i + b_i;
			vi_pkg::ALU_SUB: result_o = a_i - b_i;
			vi_pkg::ALU_AND: result_o = a_i & b_i;
			vi_pkg::ALU_OR: result_o = a_i | b_i;
			vi_pkg::ALU_XOR: result_o = a_i ^ b_i;
			vi_pkg::ALU_MUL: result_o = product;
			default: result_o = '0;
		endcase
	end

endmodule

/* design/vi_mult_pipe.sv */
// Multiply delay line

`timescale 1ns/100ps

module vi_mult_pipe #(
	parameter int MUL_STAGES = 5
) (
	input  logic                              clk_i,
	input  logic                              arst_n_i,
	input  logic                              valid_i,
	input  vi_pkg::reg_idx_t                  rd_i,
	input  vi_pkg::word_t                     product_i,
	output logic [MUL_STAGES-1:0]             stage_valid_o,
	output vi_pkg::reg_idx_t [MUL_STAGES-1:0] stage_rd_o,
	output logic                              valid_o,
	output vi_pkg::reg_idx_t                  rd_o,
	output vi_pkg::word_t                     data_o
);

	// Entry 0 is the execute stage, the rest are latched
	logic [MUL_STAGES-2:0] vld_q;
	vi_pkg::reg_idx_t [MUL_STAGES-2:0] rd_q;
	vi_pkg::word_t [MUL_STAGES-2:0] data_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= valid_i;
			for (int i = 1; i < MUL_STAGES - 1; i++) begin
				vld_q[i] <= vld_q[i-1];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		rd_q[0] <= rd_i;
		data_q[0] <= product_i;
		for (int i = 1; i < MUL_STAGES - 1; i++) begin
			rd_q[i] <= rd_q[i-1];
			data_q[i] <= data_q[i-1];
		end
	end

	assign stage_valid_o = {vld_q, valid_i};
	assign stage_rd_o = {rd_q, rd_i};

	// Last entry goes to the writeback latch
	assign valid_o = vld_q[MUL_STAGES-2];
	assign rd_o = rd_q[MUL_STAGES-2];
	assign data_o = data_q[MUL_STAGES-2];

endmodule

/* design/vi_core.sv */
// Integer core top level

`timescale 1ns/100ps

module vi_core #(
	parameter int            MUL_STAGES = 5,
	parameter vi_pkg::addr_t RESET_PC = '0
) (
	input  logic             clk_i,
	input  logic             arst_n_i,
	output logic             cyc_o,
	output logic             stb_o,
	output vi_pkg::addr_t    adr_o,
	input  vi_pkg::word_t    dat_i,
	input  logic             ack_i,
	output logic             wb_valid_o,
	output vi_pkg::reg_idx_t wb_addr_o,
	output vi_pkg::word_t    wb_data_o
);

	// Fetch to decode
	logic instr_valid;
	vi_pkg::word_t instr;
	logic dec_ready;
	logic dec_stall;
	logic dec_accept;

	// Decode
	vi_pkg::reg_idx_t dec_rs1;
	vi_pkg::reg_idx_t dec_rs2;
	vi_pkg::reg_idx_t dec_rd;
	vi_pkg::word_t dec_imm;
	logic dec_use_imm;
	vi_pkg::alu_op_t dec_op;
	logic dec_wr_en;
	logic dec_is_mul;
	vi_pkg::word_t reg_a;
	vi_pkg::word_t reg_b;
	vi_pkg::word_t fwd_a;
	vi_pkg::word_t fwd_b;

	// Execute latch
	logic exe_wr_en_q;
	logic exe_is_mul_q;
	vi_pkg::alu_op_t exe_op_q;
	vi_pkg::word_t exe_a_q;
	vi_pkg::word_t exe_b_q;
	vi_pkg::reg_idx_t exe_rd_q;
	vi_pkg::word_t alu_result;

	// Multiply chain
	logic [MUL_STAGES-1:0] mul_stage_valid;
	vi_pkg::reg_idx_t [MUL_STAGES-1:0] mul_stage_rd;
	logic mul_valid;
	vi_pkg::reg_idx_t mul_rd;
	vi_pkg::word_t mul_data;

	// Writeback latch
	logic wb_valid_q;
	vi_pkg::reg_idx_t wb_rd_q;
	vi_pkg::word_t wb_data_q;

	assign dec_ready = !dec_stall;
	assign dec_accept = instr_valid && dec_ready;

	vi_fetch_fsm #(
		.RESET_PC	(RESET_PC)
	) vi_fetch_fsm (
		.clk_i		(clk_i),
		.arst_n_i	(arst_n_i),
		.ack_i		(ack_i),
		.dat_i		(dat_i),
		.instr_ready_i	(dec_ready),
		.cyc_o		(cyc_o),
		.stb_o		(stb_o),
		.adr_o		(adr_o),
		.instr_valid_o	(instr_valid),
		.instr_o	(instr)
	);

	vi_decoder vi_decoder (
		.instr_i	(instr),
		.rs1_o		(dec_rs1),
		.rs2_o		(dec_rs2),
		.rd_o		(dec_rd),
		.imm_o		(dec_imm),
		.use_imm_o	(dec_use_imm),
		.alu_op_o	(dec_op),
		.wr_en_o	(dec_wr_en),
		.is_mul_o	(dec_is_mul)
	);

	vi_int_registers vi_int_registers (
		.clk_i		(clk_i),
		.arst_n_i	(arst_n_i),
		.rd_addr_a_i	(dec_rs1),
		.rd_addr_b_i	(dec_rs2),
		.wr_addr_i	(wb_rd_q),
		.wr_data_i	(wb_data_q),
		.wr_en_i	(wb_valid_q),
		.rd_data_a_o	(reg_a),
		.rd_data_b_o	(reg_b)
	);

	vi_hazard_ctrl #(
		.MUL_STAGES	(MUL_STAGES)
	) vi_hazard_ctrl (
		.dec_rs1_i	(dec_rs1),
		.dec_rs2_i	(dec_rs2),
		.dec_use_imm_i	(dec_use_imm),
		.dec_is_mul_i	(dec_is_mul),
		.reg_a_i	(reg_a),
		.reg_b_i	(reg_b),
		.exe_rd_i	(exe_rd_q),
		.exe_wr_en_i	(exe_wr_en_q),
		.exe_is_mul_i	(exe_is_mul_q),
		.exe_data_i	(alu_result),
		.mul_rd_i	(mul_stage_rd),
		.mul_valid_i	(mul_stage_valid),
		.wb_rd_i	(wb_rd_q),
		.wb_wr_en_i	(wb_valid_q),
		.wb_data_i	(wb_data_q),
		.op_a_o		(fwd_a),
		.op_b_o		(fwd_b),
		.stall_o	(dec_stall)
	);

	// Decode to execute, a bubble when nothing is handed over
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exe_wr_en_q <= 1'b0;
			exe_is_mul_q <= 1'b0;
		end else begin
			exe_wr_en_q <= dec_accept && dec_wr_en;
			exe_is_mul_q <= dec_accept && dec_is_mul;
		end
	end

	always_ff @(posedge clk_i) begin
		if (dec_accept) begin
			exe_op_q <= dec_op;
			exe_a_q <= fwd_a;
			exe_b_q <= dec_use_imm ? dec_imm : fwd_b;
			exe_rd_q <= dec_rd;
		end
	end

	vi_int_alu vi_int_alu (
		.op_i		(exe_op_q),
		.a_i		(exe_a_q),
		.b_i		(exe_b_q),
		.result_o	(alu_result)
	);

	vi_mult_pipe #(
		.MUL_STAGES	(MUL_STAGES)
	) vi_mult_pipe (
		.clk_i		(clk_i),
		.arst_n_i	(arst_n_i),
		.valid_i	(exe_is_mul_q && exe_wr_en_q),
		.rd_i		(exe_rd_q),
		.product_i	(alu_result),
		.stage_valid_o	(mul_stage_valid),
		.stage_rd_o	(mul_stage_rd),
		.valid_o	(mul_valid),
		.rd_o		(mul_rd),
		.data_o		(mul_data)
	);

	// Writeback, the decode stall keeps the two sources apart
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= mul_valid || (exe_wr_en_q && !exe_is_mul_q);
		end
	end

	always_ff @(posedge clk_i) begin
		wb_rd_q <= mul_valid ? mul_rd : exe_rd_q;
		wb_data_q <= mul_valid ? mul_data : alu_result;
	end

	assign wb_valid_o = wb_valid_q;
	assign wb_addr_o = wb_rd_q;
	assign wb_data_o = wb_data_q;

endmodule

/* dv/vi_core_tb.sv */
// Core testbench

`timescale 1ns/100ps

module vi_core_tb;

	localparam int MAX_WORDS = 64;
	localparam int MAX_RECORDS = 64;
	localparam int RETIRE_TIMEOUT = 200;
	localparam int FETCH_TIMEOUT = 20;
	localparam int DRAIN_CYCLES = 40;
	localparam int ROUNDS = 2;
	localparam vi_pkg::addr_t EXP_RESET_PC = 32'h0;

	logic clk_i;
	logic arst_n_i = 1'b0;
	logic ack_i = 1'b0;
	vi_pkg::word_t dat_i = '0;
	logic cyc_o;
	logic stb_o;
	vi_pkg::addr_t adr_o;
	logic wb_valid_o;
	vi_pkg::reg_idx_t wb_addr_o;
	vi_pkg::word_t wb_data_o;

	vi_pkg::word_t prog [MAX_WORDS];
	vi_pkg::word_t exp_rd [MAX_RECORDS];
	vi_pkg::word_t exp_data [MAX_RECORDS];
	int prog_len;
	int rec_count;
	int waits_left;
	logic ack_seen = 1'b0;
	integer seed;
	int fd;
	int errors;
	int tests_run;
	int tests_failed;
	string test_name;

	vi_core UUT (
		.clk_i		(clk_i),
		.arst_n_i	(arst_n_i),
		.cyc_o		(cyc_o),
		.stb_o		(stb_o),
		.adr_o		(adr_o),
		.dat_i		(dat_i),
		.ack_i		(ack_i),
		.wb_valid_o	(wb_valid_o),
		.wb_addr_o	(wb_addr_o),
		.wb_data_o	(wb_data_o)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#10 clk_i = ~clk_i;
		end
	end

	// Program words by word address and NOPs past the end
	function automatic vi_pkg::word_t fetch_word(input vi_pkg::addr_t adr);
		vi_pkg::addr_t idx;
		idx = adr >> 2;
		if (idx < prog_len) begin
			return prog[idx];
		end
		return vi_pkg::NOP_WORD;
	endfunction

	// Wishbone slave with 0 to 3 wait states per read
	always @(posedge clk_i) begin
		if (!arst_n_i) begin
			ack_i <= 1'b0;
			waits_left <= $unsigned($random(seed)) % 4;
		end else if (ack_i) begin
			ack_i <= 1'b0;
		end else if (cyc_o && stb_o) begin
			if (waits_left == 0) begin
				ack_i <= 1'b1;
				dat_i <= fetch_word(adr_o);
				waits_left <= $unsigned($random(seed)) % 4;
			end else begin
				waits_left <= waits_left - 1;
			end
		end
	end

	task automatic check_value(input string what, input vi_pkg::word_t expected,
			input vi_pkg::word_t actual);
		if (actual !== expected) begin
			$display("** Error: test %s, %s: expected %h, actual %h",
				test_name, what, expected, actual);
			errors++;
		end
	endtask

	// Strobes move together and drop for a cycle after every ack
	always @(negedge clk_i) begin
		check_value("stb_o against cyc_o", 32'(cyc_o), 32'(stb_o));
		if (ack_seen) begin
			check_value("cyc_o after ack", 32'h0, 32'(cyc_o));
		end
		ack_seen = ack_i;
	end

	task automatic read_token(output string tok);
		string rest;
		int n;
		tok = "";
		n = $fscanf(fd, "%s", tok);
		// A hash skips the rest of its line
		while (n == 1 && tok.substr(0, 0) == "#") begin
			n = $fgets(rest, fd);
			n = $fscanf(fd, "%s", tok);
		end
		if (n != 1) begin
			tok = "";
		end
	endtask

	task automatic reset_dut();
		int cycles;
		@(posedge clk_i);
		arst_n_i <= 1'b0;
		repeat (8) begin
			@(negedge clk_i);
			check_value("cyc_o in reset", 32'h0, 32'(cyc_o));
			check_value("wb_valid_o in reset", 32'h0, 32'(wb_valid_o));
		end
		@(posedge clk_i);
		arst_n_i <= 1'b1;
		@(negedge clk_i);
		check_value("cyc_o after reset", 32'h0, 32'(cyc_o));
		check_value("wb_valid_o after reset", 32'h0, 32'(wb_valid_o));
		// First read goes to the reset vector
		cycles = 0;
		while (!cyc_o && cycles < FETCH_TIMEOUT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (cyc_o) begin
			check_value("first fetch address", EXP_RESET_PC, adr_o);
		end else begin
			$display("Test %s: no bus cycle started after reset", test_name);
			errors++;
		end
	endtask

	task automatic run_test();
		int err_start;
		int got;
		int cycles;
		bit timed_out;
		err_start = errors;
		got = 0;
		timed_out = 1'b0;
		reset_dut();
		while (got < rec_count && !timed_out) begin
			cycles = 0;
			do begin
				@(negedge clk_i);
				cycles++;
			end while (!wb_valid_o && cycles < RETIRE_TIMEOUT);
			if (wb_valid_o) begin
				check_value($sformatf("record %0d register", got), exp_rd[got],
					32'(wb_addr_o));
				check_value($sformatf("record %0d value", got), exp_data[got], wb_data_o);
				got++;
			end else begin
				$display("Test %s: timed out waiting for retire record %0d of %0d",
					test_name, got + 1, rec_count);
				errors++;
				timed_out = 1'b1;
			end
		end
		// Trailing NOPs never retire
		if (!timed_out) begin
			repeat (DRAIN_CYCLES) begin
				@(negedge clk_i);
				if (wb_valid_o) begin
					$display("Test %s: unexpected retire record for x%0d",
						test_name, wb_addr_o);
					errors++;
				end
			end
		end
		tests_run++;
		if (errors == err_start) begin
			$display("Test %s passed with %0d records", test_name, rec_count);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", test_name, errors - err_start);
		end
	endtask

	initial begin
		string tok;
		seed = 32'hc3c1_1c54;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		// Second round repeats every test with other wait states
		for (int round = 0; round < ROUNDS; round++) begin
			fd = $fopen("dv/vi_tests.txt", "r");
			if (fd == 0) begin
				$display("Cannot open the test file dv/vi_tests.txt");
				errors++;
			end else begin
				read_token(tok);
				while (tok == "test") begin
					read_token(test_name);
					read_token(tok);
					prog_len = tok.atoi();
					read_token(tok);
					rec_count = tok.atoi();
					for (int i = 0; i < prog_len; i++) begin
						read_token(tok);
						prog[i] = tok.atohex();
					end
					for (int i = 0; i < rec_count; i++) begin
						read_token(tok);
						exp_rd[i] = tok.atohex();
						read_token(tok);
						exp_data[i] = tok.atohex();
					end
					run_test();
					read_token(tok);
				end
				if (tok != "") begin
					$display("Unexpected token %s in the test file", tok);
					errors++;
				end
				$fclose(fd);
			end
		end
		$display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* dv/vi_tests.txt */
# Header line is test <name> <word count> <record count>
# followed by the program words and then <register> <value> retire records, all in hex
test alu_ops 9 9
06400093 03a00113 002081b3 40208233 0020f2b3
0020e333 0020c3b3 ffb00413 401104b3
01 00000064  02 0000003a  03 0000009e
04 0000002a  05 00000020  06 0000007e
07 0000005e  08 fffffffb  09 ffffffd6
test forward_chain 7 7
00700093 00308113 002101b3 40118233 003242b3
fff28293 0042e333
01 00000007  02 0000000a  03 00000014
04 0000000d  05 00000019  05 00000018
06 0000001d
test multiply 9 9
00c00093 ffd00113 022081b3 00118233 021082b3
02220333 005303b3 00900413 0043c4b3
01 0000000c  02 fffffffd  03 ffffffdc
04 ffffffe8  05 00000090  06 00000048
07 000000d8  08 00000009  09 ffffff30
test x0_and_unknown 10 4
00500013 01500093 ffffffff 00000000 00108033
00100133 401001b3 02108033 00006233 001092b3
01 00000015  02 00000015  03 ffffffeb
04 00000000

/* all.f */
design/vi_pkg.sv
design/vi_fetch_fsm.sv
design/vi_decoder.sv
design/vi_int_registers.sv
design/vi_hazard_ctrl.sv
design/vi_int_alu.sv
design/vi_mult_pipe.sv
design/vi_core.sv
dv/vi_core_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module vi_core_tb -o vi_core_sim
out=$(./obj_dir/vi_core_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'No errors'; then
	exit 0
fi
exit 1
